// ==== rtl/res_table_cfg_pkg.sv ====
package res_table_cfg_pkg;

   localparam int CU_ID_W   = 1;
   localparam int SLOT_ID_W = 6;
   localparam int RES_ID_W  = 10;   // resource size is one bit wider

   // link codes outside the slot range
   localparam logic [SLOT_ID_W-1:0] SLOT_END  = '1;              // last entry, empty list
   localparam logic [SLOT_ID_W-1:0] SLOT_HEAD = SLOT_END - 1'b1; // prev link of first entry

   // one list node, 33 bits
   typedef struct packed {
      logic [SLOT_ID_W-1:0] next;
      logic [SLOT_ID_W-1:0] prev;
      logic [RES_ID_W:0]    size;
      logic [RES_ID_W-1:0]  start;
   } res_entry_t;

   // relink helpers
   function automatic res_entry_t set_prev(res_entry_t e, logic [SLOT_ID_W-1:0] s);
      res_entry_t r;
      r      = e;
      r.prev = s;
      return r;
   endfunction

   function automatic res_entry_t set_next(res_entry_t e, logic [SLOT_ID_W-1:0] s);
      res_entry_t r;
      r      = e;
      r.next = s;
      return r;
   endfunction

endpackage

// ==== rtl/res_table_fsm_pkg.sv ====
package res_table_fsm_pkg;

   // main sequencer
   typedef enum logic [1:0] {M_IDLE, M_ALLOC, M_DEALLOC, M_SEARCH} main_state_t;

   // list insert
   typedef enum logic [1:0] {A_IDLE, A_FIND_POS, A_UPDATE_PREV, A_WRITE_NEW} alloc_state_t;

   // list unlink
   typedef enum logic [2:0] {
      D_IDLE,
      D_READ_ENTRY,
      D_READ_NEXT,
      D_UPDATE_PREV,
      D_UPDATE_NEXT
   } dealloc_state_t;

   // free gap walk
   typedef enum logic [1:0] {S_IDLE, S_FIRST_ITEM, S_SEARCHING, S_LAST_ITEM} search_state_t;

endpackage

// ==== rtl/table_port_if.sv ====
`timescale 1ns/1ps

interface table_port_if
   import res_table_cfg_pkg::*;
();
   logic                 rd_en;
   logic                 wr_en;
   logic [SLOT_ID_W-1:0] slot;
   res_entry_t           wr_entry;
   res_entry_t           rd_entry;       // valid with rd_valid
   logic                 rd_valid;
   res_entry_t           last_rd_entry;  // entry read before rd_entry

   modport fsm (output rd_en, wr_en, slot, wr_entry,
                input  rd_entry, rd_valid, last_rd_entry);

   modport ram (input  rd_en, wr_en, slot, wr_entry,
                output rd_entry, rd_valid, last_rd_entry);
endinterface

// ==== rtl/res_entry_ram.sv ====
`timescale 1ns/1ps

module res_entry_ram
   import res_table_cfg_pkg::*;
#(
   parameter int NUM_CU       = 2,
   parameter int SLOTS_PER_CU = 40
) (
   input  logic               clk,
   input  logic               rst,
   input  logic [CU_ID_W-1:0] cu_i,
   table_port_if.ram          alloc_p,
   table_port_if.ram          dealloc_p,
   table_port_if.ram          search_p
);

   localparam int DEPTH  = NUM_CU * SLOTS_PER_CU;
   localparam int ADDR_W = $clog2(DEPTH);

   res_entry_t           mem [DEPTH];
   logic                 rd_en;
   logic                 wr_en;
   logic [SLOT_ID_W-1:0] slot;
   res_entry_t           wr_entry;
   logic [ADDR_W-1:0]    addr;
   res_entry_t           rd_entry;
   res_entry_t           last_rd_entry;
   logic                 rd_valid;

   ////////////////////////////////////////
   // port merge, one sequencer active at a time
   always_comb begin
      rd_en = alloc_p.rd_en | dealloc_p.rd_en | search_p.rd_en;
      wr_en = alloc_p.wr_en | dealloc_p.wr_en | search_p.wr_en;
      if (alloc_p.rd_en || alloc_p.wr_en) begin
         slot     = alloc_p.slot;
         wr_entry = alloc_p.wr_entry;
      end else if (dealloc_p.rd_en || dealloc_p.wr_en) begin
         slot     = dealloc_p.slot;
         wr_entry = dealloc_p.wr_entry;
      end else begin
         slot     = search_p.slot;
         wr_entry = search_p.wr_entry;
      end
   end

   assign addr = ADDR_W'(cu_i * SLOTS_PER_CU + slot);  // cu major

   ////////////////////////////////////////
   // storage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin                 // read beats write
         rd_entry      <= mem[addr];
         last_rd_entry <= rd_entry;
      end else if (wr_en) begin
         mem[addr] <= wr_entry;
      end
   end

   // same read data back to every port
   assign alloc_p.rd_entry        = rd_entry;
   assign alloc_p.rd_valid        = rd_valid;
   assign alloc_p.last_rd_entry   = last_rd_entry;
   assign dealloc_p.rd_entry      = rd_entry;
   assign dealloc_p.rd_valid      = rd_valid;
   assign dealloc_p.last_rd_entry = last_rd_entry;
   assign search_p.rd_entry       = rd_entry;
   assign search_p.rd_valid       = rd_valid;
   assign search_p.last_rd_entry  = last_rd_entry;

endmodule

// ==== rtl/res_alloc_fsm.sv ====
`timescale 1ns/1ps

module res_alloc_fsm
   import res_table_cfg_pkg::*;
   import res_table_fsm_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start_i,
   input  logic [SLOT_ID_W-1:0] slot_i,
   input  logic [RES_ID_W-1:0]  start_addr_i,
   input  logic [RES_ID_W:0]    size_i,
   input  logic [SLOT_ID_W-1:0] head_i,
   output logic                 head_wr_o,
   output logic [SLOT_ID_W-1:0] head_o,
   output logic                 done_o,
   table_port_if.fsm            tp
);

   alloc_state_t state;
   logic         is_first;  // new entry becomes head
   logic         is_last;   // new entry becomes tail

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= A_IDLE;
         is_first    <= 1'b0;
         is_last     <= 1'b0;
         head_wr_o   <= 1'b0;
         head_o      <= SLOT_END;
         done_o      <= 1'b0;
         tp.rd_en    <= 1'b0;
         tp.wr_en    <= 1'b0;
         tp.slot     <= '0;
         tp.wr_entry <= '0;
      end else begin
         tp.rd_en  <= 1'b0;
         tp.wr_en  <= 1'b0;
         head_wr_o <= 1'b0;
         done_o    <= 1'b0;
         case (state)
            A_IDLE: begin
               if (start_i) begin
                  if (head_i == SLOT_END) begin  // empty list, write straight away
                     is_first <= 1'b1;
                     is_last  <= 1'b1;
                     state    <= A_WRITE_NEW;
                  end else begin
                     is_first <= 1'b0;
                     is_last  <= 1'b0;
                     tp.rd_en <= 1'b1;
                     tp.slot  <= head_i;
                     state    <= A_FIND_POS;
                  end
               end
            end

            A_FIND_POS: begin
               if (tp.rd_valid) begin
                  if (tp.rd_entry.start > start_addr_i) begin
                     // this entry follows the new one
                     tp.wr_en    <= 1'b1;
                     tp.wr_entry <= set_prev(tp.rd_entry, slot_i);
                     if (tp.rd_entry.prev == SLOT_HEAD) begin
                        is_first <= 1'b1;
                        state    <= A_WRITE_NEW;
                     end else begin
                        state <= A_UPDATE_PREV;
                     end
                  end else if (tp.rd_entry.next == SLOT_END) begin
                     tp.wr_en    <= 1'b1;                      // append at tail
                     tp.wr_entry <= set_next(tp.rd_entry, slot_i);
                     is_last     <= 1'b1;
                     state       <= A_WRITE_NEW;
                  end else begin
                     tp.rd_en <= 1'b1;                         // keep walking
                     tp.slot  <= tp.rd_entry.next;
                  end
               end
            end

            A_UPDATE_PREV: begin
               // last_rd_entry is the entry before the insert point
               tp.wr_en    <= 1'b1;
               tp.wr_entry <= set_next(tp.last_rd_entry, slot_i);
               tp.slot     <= tp.rd_entry.prev;
               state       <= A_WRITE_NEW;
            end

            A_WRITE_NEW: begin
               tp.wr_en          <= 1'b1;
               tp.slot           <= slot_i;
               tp.wr_entry.start <= start_addr_i;
               tp.wr_entry.size  <= size_i;
               tp.wr_entry.prev  <= is_first ? SLOT_HEAD : tp.slot;
               if (is_last) begin
                  tp.wr_entry.next <= SLOT_END;
               end else if (is_first) begin
                  tp.wr_entry.next <= tp.slot;                 // old head
               end else begin
                  tp.wr_entry.next <= tp.last_rd_entry.next;
               end
               if (is_first) begin
                  head_wr_o <= 1'b1;
                  head_o    <= slot_i;
               end
               done_o <= 1'b1;
               state  <= A_IDLE;
            end

            default: state <= A_IDLE;
         endcase
      end
   end

endmodule

// ==== rtl/res_dealloc_fsm.sv ====
`timescale 1ns/1ps

module res_dealloc_fsm
   import res_table_cfg_pkg::*;
   import res_table_fsm_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start_i,
   input  logic [SLOT_ID_W-1:0] slot_i,
   output logic                 head_wr_o,
   output logic [SLOT_ID_W-1:0] head_o,
   output logic                 done_o,
   table_port_if.fsm            tp
);

   dealloc_state_t state;
   logic           is_first;
   logic           is_last;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= D_IDLE;
         is_first    <= 1'b0;
         is_last     <= 1'b0;
         head_wr_o   <= 1'b0;
         head_o      <= SLOT_END;
         done_o      <= 1'b0;
         tp.rd_en    <= 1'b0;
         tp.wr_en    <= 1'b0;
         tp.slot     <= '0;
         tp.wr_entry <= '0;
      end else begin
         tp.rd_en  <= 1'b0;
         tp.wr_en  <= 1'b0;
         head_wr_o <= 1'b0;
         done_o    <= 1'b0;
         case (state)
            D_IDLE: begin
               if (start_i) begin
                  is_first <= 1'b0;
                  is_last  <= 1'b0;
                  tp.rd_en <= 1'b1;
                  tp.slot  <= slot_i;
                  state    <= D_READ_ENTRY;
               end
            end

            D_READ_ENTRY: begin
               if (tp.rd_valid) begin
                  if (tp.rd_entry.prev == SLOT_HEAD && tp.rd_entry.next == SLOT_END) begin
                     head_wr_o <= 1'b1;   // only entry, list becomes empty
                     head_o    <= SLOT_END;
                     done_o    <= 1'b1;
                     state     <= D_IDLE;
                  end else if (tp.rd_entry.prev == SLOT_HEAD) begin
                     is_first <= 1'b1;    // next entry read one state later
                     state    <= D_READ_NEXT;
                  end else begin
                     is_last  <= (tp.rd_entry.next == SLOT_END);
                     tp.rd_en <= 1'b1;    // fetch previous neighbour
                     tp.slot  <= tp.rd_entry.prev;
                     state    <= D_READ_NEXT;
                  end
               end
            end

            D_READ_NEXT: begin
               // rd_entry still holds the removed entry here
               if (!is_last) begin
                  tp.rd_en <= 1'b1;
                  tp.slot  <= tp.rd_entry.next;
               end
               state <= D_UPDATE_PREV;
            end

            D_UPDATE_PREV: begin
               if (!is_first && !is_last) begin
                  // rd_entry is prev neighbour, slot points at next one
                  tp.wr_en    <= 1'b1;
                  tp.wr_entry <= set_next(tp.rd_entry, tp.slot);
                  tp.slot     <= tp.last_rd_entry.prev;
               end
               state <= D_UPDATE_NEXT;
            end

            D_UPDATE_NEXT: begin
               tp.wr_en <= 1'b1;
               if (is_first) begin
                  tp.wr_entry <= set_prev(tp.rd_entry, SLOT_HEAD);
                  head_wr_o   <= 1'b1;
                  head_o      <= tp.slot;   // next neighbour is new head
               end else if (is_last) begin
                  tp.wr_entry <= set_next(tp.rd_entry, SLOT_END);
               end else begin
                  tp.slot     <= tp.wr_entry.next;
                  tp.wr_entry <= set_prev(tp.rd_entry, tp.slot);
               end
               done_o <= 1'b1;
               state  <= D_IDLE;
            end

            default: state <= D_IDLE;
         endcase
      end
   end

endmodule

// ==== rtl/res_space_search.sv ====
`timescale 1ns/1ps

module res_space_search
   import res_table_cfg_pkg::*;
   import res_table_fsm_pkg::*;
#(
   parameter int NUM_RES_SLOTS = 1024
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start_i,
   input  logic [SLOT_ID_W-1:0] head_i,
   output logic                 done_o,
   output logic [RES_ID_W:0]    max_size_o,
   output logic [RES_ID_W-1:0]  max_addr_o,
   table_port_if.fsm            tp
);

   search_state_t     state;
   logic [RES_ID_W:0] prev_end;  // first free address after previous entry
   logic [RES_ID_W:0] cur_end;
   logic [RES_ID_W:0] mid_gap;
   logic [RES_ID_W:0] tail_gap;

   assign prev_end = {1'b0, tp.last_rd_entry.start} + tp.last_rd_entry.size;
   assign cur_end  = {1'b0, tp.rd_entry.start} + tp.rd_entry.size;
   assign mid_gap  = {1'b0, tp.rd_entry.start} - prev_end;
   assign tail_gap = (RES_ID_W+1)'(NUM_RES_SLOTS) - cur_end;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= S_IDLE;
         done_o      <= 1'b0;
         max_size_o  <= '0;
         max_addr_o  <= '0;
         tp.rd_en    <= 1'b0;
         tp.wr_en    <= 1'b0;
         tp.slot     <= '0;
         tp.wr_entry <= '0;
      end else begin
         tp.rd_en <= 1'b0;
         tp.wr_en <= 1'b0;    // walk only reads
         done_o   <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start_i) begin
                  if (head_i == SLOT_END) begin
                     max_size_o <= (RES_ID_W+1)'(NUM_RES_SLOTS);  // whole space free
                     max_addr_o <= '0;
                     done_o     <= 1'b1;
                  end else begin
                     tp.rd_en <= 1'b1;
                     tp.slot  <= head_i;
                     state    <= S_FIRST_ITEM;
                  end
               end
            end

            S_FIRST_ITEM: begin
               if (tp.rd_valid) begin
                  max_size_o <= {1'b0, tp.rd_entry.start};  // gap below first entry
                  max_addr_o <= '0;
                  if (tp.rd_entry.next != SLOT_END) begin
                     tp.rd_en <= 1'b1;
                     tp.slot  <= tp.rd_entry.next;
                     state    <= S_SEARCHING;
                  end else begin
                     state <= S_LAST_ITEM;
                  end
               end
            end

            S_SEARCHING: begin
               if (tp.rd_valid) begin
                  if (tp.rd_entry.next != SLOT_END) begin
                     tp.rd_en <= 1'b1;
                     tp.slot  <= tp.rd_entry.next;
                  end else begin
                     state <= S_LAST_ITEM;
                  end
                  if (mid_gap > max_size_o) begin  // strictly larger keeps the lowest gap
                     max_size_o <= mid_gap;
                     max_addr_o <= prev_end[RES_ID_W-1:0];
                  end
               end
            end

            S_LAST_ITEM: begin
               if (tail_gap > max_size_o) begin
                  max_size_o <= tail_gap;
                  max_addr_o <= cur_end[RES_ID_W-1:0];
               end
               done_o <= 1'b1;
               state  <= S_IDLE;
            end

            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// ==== rtl/res_table.sv ====
`timescale 1ns/1ps

module res_table
   import res_table_cfg_pkg::*;
   import res_table_fsm_pkg::*;
#(
   parameter int NUM_CU        = 2,
   parameter int SLOTS_PER_CU  = 40,
   parameter int NUM_RES_SLOTS = 1024
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 alloc_en_i,
   input  logic [CU_ID_W-1:0]   alloc_cu_i,
   input  logic [SLOT_ID_W-1:0] alloc_slot_i,
   input  logic [RES_ID_W-1:0]  alloc_start_i,
   input  logic [RES_ID_W:0]    alloc_size_i,
   input  logic                 dealloc_en_i,
   input  logic [CU_ID_W-1:0]   dealloc_cu_i,
   input  logic [SLOT_ID_W-1:0] dealloc_slot_i,
   output logic                 res_table_done_o,
   output logic [RES_ID_W:0]    biggest_size_o,
   output logic [RES_ID_W-1:0]  biggest_addr_o
);

   main_state_t          m_state;
   logic                 accept;
   logic                 alloc_q;
   logic                 dealloc_q;
   logic [CU_ID_W-1:0]   cur_cu;
   logic [SLOT_ID_W-1:0] req_slot;
   logic [RES_ID_W-1:0]  req_start;
   logic [RES_ID_W:0]    req_size;
   logic                 alloc_start;
   logic                 dealloc_start;
   logic                 search_start;
   logic                 alloc_done;
   logic                 dealloc_done;
   logic                 search_done;
   logic [SLOT_ID_W-1:0] head_q [NUM_CU];
   logic [SLOT_ID_W-1:0] head;
   logic                 alloc_head_wr;
   logic                 dealloc_head_wr;
   logic [SLOT_ID_W-1:0] alloc_head;
   logic [SLOT_ID_W-1:0] dealloc_head;
   logic [RES_ID_W:0]    search_size;
   logic [RES_ID_W-1:0]  search_addr;

   table_port_if alloc_tp ();
   table_port_if dealloc_tp ();
   table_port_if search_tp ();

   ////////////////////////////////////////
   // request capture
   assign accept = (m_state == M_IDLE) && !alloc_q && !dealloc_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         alloc_q   <= 1'b0;
         dealloc_q <= 1'b0;
         cur_cu    <= '0;
      end else begin
         alloc_q   <= accept & alloc_en_i;
         dealloc_q <= accept & dealloc_en_i & ~alloc_en_i;  // alloc wins
         if (accept && alloc_en_i) begin
            cur_cu <= alloc_cu_i;
         end else if (accept && dealloc_en_i) begin
            cur_cu <= dealloc_cu_i;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && alloc_en_i) begin
         req_slot  <= alloc_slot_i;
         req_start <= alloc_start_i;
         req_size  <= alloc_size_i;
      end else if (accept && dealloc_en_i) begin
         req_slot <= dealloc_slot_i;
      end
   end

   ////////////////////////////////////////
   // main sequencer
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         m_state          <= M_IDLE;
         alloc_start      <= 1'b0;
         dealloc_start    <= 1'b0;
         search_start     <= 1'b0;
         res_table_done_o <= 1'b0;
         biggest_size_o   <= '0;
         biggest_addr_o   <= '0;
      end else begin
         alloc_start      <= 1'b0;
         dealloc_start    <= 1'b0;
         search_start     <= 1'b0;
         res_table_done_o <= 1'b0;
         case (m_state)
            M_IDLE: begin
               if (alloc_q) begin
                  alloc_start <= 1'b1;
                  m_state     <= M_ALLOC;
               end else if (dealloc_q) begin
                  dealloc_start <= 1'b1;
                  m_state       <= M_DEALLOC;
               end
            end
            M_ALLOC: begin
               if (alloc_done) begin
                  search_start <= 1'b1;
                  m_state      <= M_SEARCH;
               end
            end
            M_DEALLOC: begin
               if (dealloc_done) begin
                  search_start <= 1'b1;
                  m_state      <= M_SEARCH;
               end
            end
            M_SEARCH: begin
               if (search_done) begin
                  res_table_done_o <= 1'b1;
                  biggest_size_o   <= search_size;   // held until next done
                  biggest_addr_o   <= search_addr;
                  m_state          <= M_IDLE;
               end
            end
            default: m_state <= M_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // head pointers, one per cu
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_CU; i++) begin
            head_q[i] <= SLOT_END;   // every list starts empty
         end
      end else if (alloc_head_wr) begin
         head_q[cur_cu] <= alloc_head;
      end else if (dealloc_head_wr) begin
         head_q[cur_cu] <= dealloc_head;
      end
   end

   assign head = head_q[cur_cu];

   res_entry_ram #(
      .NUM_CU       (NUM_CU),
      .SLOTS_PER_CU (SLOTS_PER_CU)
   ) u_ram (
      .clk       (clk),
      .rst       (rst),
      .cu_i      (cur_cu),
      .alloc_p   (alloc_tp.ram),
      .dealloc_p (dealloc_tp.ram),
      .search_p  (search_tp.ram)
   );

   res_alloc_fsm u_alloc (
      .clk          (clk),
      .rst          (rst),
      .start_i      (alloc_start),
      .slot_i       (req_slot),
      .start_addr_i (req_start),
      .size_i       (req_size),
      .head_i       (head),
      .head_wr_o    (alloc_head_wr),
      .head_o       (alloc_head),
      .done_o       (alloc_done),
      .tp           (alloc_tp.fsm)
   );

   res_dealloc_fsm u_dealloc (
      .clk       (clk),
      .rst       (rst),
      .start_i   (dealloc_start),
      .slot_i    (req_slot),
      .head_wr_o (dealloc_head_wr),
      .head_o    (dealloc_head),
      .done_o    (dealloc_done),
      .tp        (dealloc_tp.fsm)
   );

   res_space_search #(
      .NUM_RES_SLOTS (NUM_RES_SLOTS)
   ) u_search (
      .clk        (clk),
      .rst        (rst),
      .start_i    (search_start),
      .head_i     (head),
      .done_o     (search_done),
      .max_size_o (search_size),
      .max_addr_o (search_addr),
      .tp         (search_tp.fsm)
   );

endmodule

// ==== sim/tb_res_table.sv ====
`timescale 1ns/1ps

module tb_res_table
   import res_table_cfg_pkg::*;
();

   localparam int NUM_CU        = 2;
   localparam int SLOTS_PER_CU  = 40;
   localparam int NUM_RES_SLOTS = 1024;
   localparam int WAIT_LIMIT    = 500;   // cycles per request

   logic                 clk;
   logic                 rst;
   logic                 alloc_en_i;
   logic [CU_ID_W-1:0]   alloc_cu_i;
   logic [SLOT_ID_W-1:0] alloc_slot_i;
   logic [RES_ID_W-1:0]  alloc_start_i;
   logic [RES_ID_W:0]    alloc_size_i;
   logic                 dealloc_en_i;
   logic [CU_ID_W-1:0]   dealloc_cu_i;
   logic [SLOT_ID_W-1:0] dealloc_slot_i;
   logic                 res_table_done_o;
   logic [RES_ID_W:0]    biggest_size_o;
   logic [RES_ID_W-1:0]  biggest_addr_o;

   int seed;
   int err_count;
   int done_count;
   int exp_size;
   int exp_addr;
   bit pending;     // request sent, done not yet seen
   bit req_seen;
   bit timed_out;   // a request never got its done

   // reference model, one entry per cu and slot
   bit live    [NUM_CU][SLOTS_PER_CU];
   int m_start [NUM_CU][SLOTS_PER_CU];
   int m_size  [NUM_CU][SLOTS_PER_CU];

   res_table #(
      .NUM_CU        (NUM_CU),
      .SLOTS_PER_CU  (SLOTS_PER_CU),
      .NUM_RES_SLOTS (NUM_RES_SLOTS)
   ) UUT (
      .clk              (clk),
      .rst              (rst),
      .alloc_en_i       (alloc_en_i),
      .alloc_cu_i       (alloc_cu_i),
      .alloc_slot_i     (alloc_slot_i),
      .alloc_start_i    (alloc_start_i),
      .alloc_size_i     (alloc_size_i),
      .dealloc_en_i     (dealloc_en_i),
      .dealloc_cu_i     (dealloc_cu_i),
      .dealloc_slot_i   (dealloc_slot_i),
      .res_table_done_o (res_table_done_o),
      .biggest_size_o   (biggest_size_o),
      .biggest_addr_o   (biggest_addr_o)
   );

   always #20 clk = ~clk;

   ////////////////////////////////////////
   // checks
   a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
      !req_seen |-> (!res_table_done_o && biggest_size_o == 0 && biggest_addr_o == 0))
      else begin
         err_count++;
         $display("Error at %0t: outputs not idle before first request", $time);
      end

   a_gap_match: assert property (@(posedge clk) disable iff (rst)
      res_table_done_o |-> (biggest_size_o == exp_size && biggest_addr_o == exp_addr))
      else begin
         err_count++;
         $display("Error at %0t: gap %0d at %0d, expected %0d at %0d", $time,
                  $sampled(biggest_size_o), $sampled(biggest_addr_o), exp_size, exp_addr);
      end

   a_done_single: assert property (@(posedge clk) disable iff (rst)
      res_table_done_o |=> !res_table_done_o)
      else begin
         err_count++;
         $display("Error at %0t: done high for two cycles", $time);
      end

   a_done_owed: assert property (@(posedge clk) disable iff (rst)
      res_table_done_o |-> pending)
      else begin
         err_count++;
         $display("Error at %0t: done without an outstanding request", $time);
      end

   ////////////////////////////////////////
   // model helpers
   task automatic compute_expected(input int cu);
      int s [$];
      int z [$];
      int idx;
      int prev_end;
      int gap;
      for (int i = 0; i < SLOTS_PER_CU; i++) begin
         if (live[cu][i]) begin
            idx = 0;
            while (idx < s.size() && s[idx] < m_start[cu][i]) idx++;  // keep sorted
            s.insert(idx, m_start[cu][i]);
            z.insert(idx, m_size[cu][i]);
         end
      end
      prev_end = 0;
      exp_size = -1;
      exp_addr = 0;
      for (int i = 0; i < s.size(); i++) begin
         gap = s[i] - prev_end;
         if (gap > exp_size) begin   // first largest wins
            exp_size = gap;
            exp_addr = prev_end;
         end
         prev_end = s[i] + z[i];
      end
      gap = NUM_RES_SLOTS - prev_end;
      if (gap > exp_size) begin
         exp_size = gap;
         exp_addr = prev_end;
      end
   endtask

   function automatic int count_live(int cu);
      int n;
      n = 0;
      for (int i = 0; i < SLOTS_PER_CU; i++) n += live[cu][i];
      return n;
   endfunction

   // slot of the r-th entry in address order
   function automatic int slot_at_rank(int cu, int r);
      int below;
      for (int i = 0; i < SLOTS_PER_CU; i++) begin
         if (live[cu][i]) begin
            below = 0;
            for (int j = 0; j < SLOTS_PER_CU; j++) begin
               if (live[cu][j] && m_start[cu][j] < m_start[cu][i]) below++;
            end
            if (below == r) return i;
         end
      end
      return -1;
   endfunction

   function automatic int free_slot(int cu);
      int s;
      s = $unsigned($random(seed)) % SLOTS_PER_CU;
      for (int i = 0; i < SLOTS_PER_CU; i++) begin
         if (!live[cu][(s + i) % SLOTS_PER_CU]) return (s + i) % SLOTS_PER_CU;
      end
      return -1;
   endfunction

   ////////////////////////////////////////
   // request drivers
   task automatic wait_done();
      int cycles;
      bit got;
      cycles = 0;
      got    = 0;
      while (!got && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         got = res_table_done_o;
         cycles++;
      end
      if (got) begin
         done_count++;
         @(posedge clk);
         pending = 0;
         #2;
      end else begin
         $display("timeout: no done within %0d cycles of a request", WAIT_LIMIT);
         err_count++;
         timed_out = 1;
      end
   endtask

   task automatic do_alloc(input int cu, input int slot, input int st, input int sz);
      live[cu][slot]    = 1;
      m_start[cu][slot] = st;
      m_size[cu][slot]  = sz;
      compute_expected(cu);
      if (timed_out) return;   // table is stuck, skip the rest
      alloc_en_i    = 1'b1;
      alloc_cu_i    = cu[CU_ID_W-1:0];
      alloc_slot_i  = slot[SLOT_ID_W-1:0];
      alloc_start_i = st[RES_ID_W-1:0];
      alloc_size_i  = sz[RES_ID_W:0];
      req_seen      = 1;
      pending       = 1;
      @(posedge clk);
      #2 alloc_en_i = 1'b0;
      wait_done();
   endtask

   task automatic dealloc_rank(input int cu, input int r);
      int slot;
      slot           = slot_at_rank(cu, r);
      live[cu][slot] = 0;
      compute_expected(cu);
      if (timed_out) return;
      dealloc_en_i   = 1'b1;
      dealloc_cu_i   = cu[CU_ID_W-1:0];
      dealloc_slot_i = slot[SLOT_ID_W-1:0];
      pending        = 1;
      @(posedge clk);
      #2 dealloc_en_i = 1'b0;
      wait_done();
   endtask

   // random range that overlaps no live range of the cu
   task automatic alloc_random(input int cu);
      int slot;
      int st;
      int sz;
      bit clash;
      slot  = free_slot(cu);
      clash = 1;
      for (int t = 0; t < 200 && clash; t++) begin
         sz    = 1 + ($unsigned($random(seed)) % 48);
         st    = $unsigned($random(seed)) % (NUM_RES_SLOTS - sz + 1);
         clash = 0;
         for (int i = 0; i < SLOTS_PER_CU; i++) begin
            if (live[cu][i] && st < m_start[cu][i] + m_size[cu][i] &&
                m_start[cu][i] < st + sz) clash = 1;
         end
      end
      if (slot >= 0 && !clash) do_alloc(cu, slot, st, sz);
   endtask

   ////////////////////////////////////////
   // stimulus
   initial begin
      int cu;
      clk            = 1'b0;
      rst            = 1'b1;
      alloc_en_i     = 1'b0;
      alloc_cu_i     = '0;
      alloc_slot_i   = '0;
      alloc_start_i  = '0;
      alloc_size_i   = '0;
      dealloc_en_i   = 1'b0;
      dealloc_cu_i   = '0;
      dealloc_slot_i = '0;
      seed           = 90247;
      err_count      = 0;
      done_count     = 0;
      exp_size       = 0;
      exp_addr       = 0;
      pending        = 0;
      req_seen       = 0;
      timed_out      = 0;

      repeat (8) @(posedge clk);
      #2 rst = 1'b0;
      repeat (4) @(posedge clk);   // idle outputs
      #2;

      do_alloc(0, 5, 300, 100);    // empty list
      do_alloc(0, 9, 10, 20);      // new head
      do_alloc(0, 12, 900, 50);    // new tail
      do_alloc(0, 3, 600, 30);     // middle
      repeat (10) alloc_random(0);

      dealloc_rank(0, 0);                   // first
      dealloc_rank(0, count_live(0) - 1);   // last
      dealloc_rank(0, count_live(0) / 2);   // middle
      while (count_live(0) > 0) begin
         dealloc_rank(0, $unsigned($random(seed)) % count_live(0));
      end

      // three equal gaps of 300
      do_alloc(1, 0, 300, 100);
      do_alloc(1, 1, 700, 24);

      // alternate cus
      for (int i = 0; i < 40; i++) begin
         cu = i % 2;
         if (count_live(cu) > 0 && ($unsigned($random(seed)) % 3) == 0) begin
            dealloc_rank(cu, $unsigned($random(seed)) % count_live(cu));
         end else begin
            alloc_random(cu);
         end
      end

      repeat (4) @(posedge clk);
      $display("requests completed: %0d, errors: %0d", done_count, err_count);
      if (err_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
rtl/res_table_cfg_pkg.sv
rtl/res_table_fsm_pkg.sv
rtl/table_port_if.sv
rtl/res_entry_ram.sv
rtl/res_alloc_fsm.sv
rtl/res_dealloc_fsm.sv
rtl/res_space_search.sv
rtl/res_table.sv
sim/tb_res_table.sv

// ==== Bender.yml ====
package:
  name: res_table

sources:
  - files:
      - rtl/res_table_cfg_pkg.sv
      - rtl/res_table_fsm_pkg.sv
      - rtl/table_port_if.sv
      - rtl/res_entry_ram.sv
      - rtl/res_alloc_fsm.sv
      - rtl/res_dealloc_fsm.sv
      - rtl/res_space_search.sv
      - rtl/res_table.sv
  - target: simulation
    files:
      - sim/tb_res_table.sv
